// File: src/hyper_ctrl_consts.svh
// widths, chip count and register-write wait for the hyperbus sequencer

`ifndef HYPER_CTRL_CONSTS_SVH
`define HYPER_CTRL_CONSTS_SVH

////////////////////////////////////////
// transfer sizing
////////////////////////////////////////

// byte and word counts
`define HC_TRANS_SIZE 16

// hyperbus byte address
`define HC_ADDR_W 32

////////////////////////////////////////
// chip selects
////////////////////////////////////////

`define HC_NR_CS 2     // memories behind the bus
`define HC_CS_SEL_W 1  // index width for HC_NR_CS chips

////////////////////////////////////////
// timing
////////////////////////////////////////

`define HC_REC_W 32    // read/write recovery counter

// the FSM stays one cycle longer than this after a register-space write
`define HC_REG_W_WAIT 4

`endif

// File: src/hyper_ctrl_pkg.sv
// state enum, lane mask and size, address and select types of the hyperbus sequencer

`include "hyper_ctrl_consts.svh"

package hyper_ctrl_pkg;

    ////////////////////////////////////////
    // sequencer states
    ////////////////////////////////////////

    typedef enum logic [2:0]
    {
        IDLE    = 3'd0,  // waiting for a descriptor
        SETUP   = 3'd1,  // launching toward the PHY
        REG_W   = 3'd2,  // fixed wait of a register write
        XFER    = 3'd3,  // counting data beats
        RECOVER = 3'd4   // read/write recovery gap
    } ctrl_state_e;

    ////////////////////////////////////////
    // data path types
    ////////////////////////////////////////

    // bit 0 masks the lower byte, bit 1 the upper byte
    typedef logic [1:0] byte_mask_t;

    // byte count of a descriptor or word count of a burst
    typedef logic [`HC_TRANS_SIZE-1:0] size_t;

    typedef logic [`HC_ADDR_W-1:0] addr_t;     // hyperbus byte address

    typedef logic [`HC_CS_SEL_W-1:0] cs_sel_t; // chip index

endpackage

// File: src/txn_if.sv
// interface for the captured descriptor and its derived burst values

`timescale 1ns/1ns

`include "hyper_ctrl_consts.svh"

interface txn_if import hyper_ctrl_pkg::*; ();

    // descriptor fields as registered on acceptance
    logic                   rw;         // 1 = read
    logic                   reg_space;  // register space access
    addr_t                  addr;
    size_t                  size;       // bytes
    logic [`HC_REC_W-1:0]   t_rec;      // recovery cycles

    // derived from the registered fields
    size_t                  words;      // 16-bit beats of the burst
    logic                   odd_start;
    logic                   tail_odd;
    logic [`HC_NR_CS-1:0]   cs_onehot;

    // descriptor register drives everything
    modport capture_mp (
        output rw, reg_space, addr, size, t_rec,
        output words, odd_start, tail_odd, cs_onehot
    );

    // state machine needs direction, burst length and timing
    modport seq_mp (
        input rw, reg_space, t_rec, words
    );

    modport mask_mp (
        input rw, size, odd_start, tail_odd
    );

endinterface

// File: src/txn_capture.sv
// descriptor register with burst word count, odd-start and tail flags and chip-select decode

`timescale 1ns/1ns

`include "hyper_ctrl_consts.svh"

module txn_capture
    import hyper_ctrl_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_ni,

    input  logic                    accept_i,        // descriptor handshake
    input  logic                    txn_rw_i,
    input  logic                    txn_reg_space_i,
    input  addr_t                   txn_addr_i,
    input  size_t                   txn_size_i,
    input  cs_sel_t                 txn_cs_i,
    input  logic [`HC_REC_W-1:0]    t_rw_recovery_i,

    txn_if.capture_mp               txn
);

    cs_sel_t    cs_q;       // registered chip index
    logic       extra_word; // partial word at the head or tail

    ////////////////////////////////////////
    // descriptor register
    ////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            txn.rw        <= 1'b0;
            txn.reg_space <= 1'b0;
            txn.addr      <= '0;
            txn.size      <= '0;
            txn.t_rec     <= '0;
            cs_q          <= '0;
        end
        else if (accept_i)
        begin
            txn.rw        <= txn_rw_i;
            txn.reg_space <= txn_reg_space_i;
            txn.addr      <= txn_addr_i;
            txn.size      <= txn_size_i;
            txn.t_rec     <= t_rw_recovery_i;
            cs_q          <= txn_cs_i;
        end
    end

    ////////////////////////////////////////
    // derived burst values
    ////////////////////////////////////////

    assign txn.odd_start = txn.addr[0];                // first word carries one byte
    assign txn.tail_odd  = txn.addr[0] ^ txn.size[0];  // last word carries one byte

    assign extra_word = txn.size[0] | txn.addr[0];

    // register writes go without data beats
    assign txn.words = (txn.reg_space && !txn.rw) ? '0
                     : (txn.size >> 1) + size_t'(extra_word);

    for (genvar k = 0; k < `HC_NR_CS; k++)
    begin : g_cs_decode
        assign txn.cs_onehot[k] = (cs_q == cs_sel_t'(k));
    end

    // an index past the last chip would leave every memory deselected
    a_cs_onehot : assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot(txn.cs_onehot));

endmodule

// File: src/trans_sequencer.sv
// transaction FSM with beat countdown, register-write wait and recovery gap

`timescale 1ns/1ns

`include "hyper_ctrl_consts.svh"

module trans_sequencer
    import hyper_ctrl_pkg::*;
(
    input  logic            clk_i,
    input  logic            rst_ni,

    // descriptor handshake
    input  logic            txn_valid_i,
    output logic            txn_ready_o,
    output logic            accept_o,

    txn_if.seq_mp           txn,

    // launch toward the PHY
    output logic            phy_trans_valid_o,
    input  logic            phy_trans_ready_i,

    // data beats, observed only
    input  logic            tx_valid_i,
    input  logic            tx_ready_i,
    input  logic            rx_valid_i,
    input  logic            rx_ready_i,

    output size_t           burst_len_o,
    output size_t           remained_o,
    output ctrl_state_e     state_o
);

    localparam int unsigned RegCntW = $clog2(`HC_REG_W_WAIT + 1);

    ctrl_state_e            state_q;
    logic [`HC_REC_W-1:0]   rec_cnt;    // recovery cycles left
    logic [RegCntW-1:0]     reg_cnt;    // register write wait
    logic                   beat;       // counted beat of this direction
    logic                   reg_write;
    logic                   xfer_done;

    assign accept_o  = txn_valid_i & txn_ready_o;
    assign reg_write = txn.reg_space & ~txn.rw;
    assign beat      = txn.rw ? (rx_valid_i & rx_ready_i) : (tx_valid_i & tx_ready_i);

    // leave XFER on the edge that takes the last beat
    assign xfer_done = (remained_o == '0) || (beat && remained_o == size_t'(1));

    assign state_o = state_q;

    ////////////////////////////////////////
    // state machine
    ////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            state_q           <= IDLE;
            txn_ready_o       <= 1'b1;
            phy_trans_valid_o <= 1'b0;
            burst_len_o       <= '0;
            remained_o        <= '0;
            rec_cnt           <= '0;
            reg_cnt           <= '0;
        end
        else
        begin
            case (state_q)
                IDLE:
                begin
                    if (accept_o)
                    begin
                        state_q     <= SETUP;
                        txn_ready_o <= 1'b0;
                    end
                    else
                    begin
                        txn_ready_o <= 1'b1;  // one cycle after leaving RECOVER
                    end
                end
                SETUP:
                begin
                    burst_len_o <= txn.words;
                    remained_o  <= txn.words;
                    if (phy_trans_valid_o && phy_trans_ready_i)
                    begin
                        phy_trans_valid_o <= 1'b0;
                        if (reg_write)
                        begin
                            reg_cnt <= RegCntW'(`HC_REG_W_WAIT);
                            state_q <= REG_W;
                        end
                        else
                        begin
                            state_q <= XFER;
                        end
                    end
                    else
                    begin
                        phy_trans_valid_o <= 1'b1;  // held through back-pressure
                    end
                end
                REG_W:
                begin
                    if (reg_cnt == '0)
                    begin
                        state_q <= RECOVER;
                        rec_cnt <= txn.t_rec;
                    end
                    else
                    begin
                        reg_cnt <= reg_cnt - RegCntW'(1);
                    end
                end
                XFER:
                begin
                    if (beat && remained_o != '0)
                        remained_o <= remained_o - size_t'(1);
                    if (xfer_done)
                    begin
                        state_q     <= RECOVER;
                        rec_cnt     <= txn.t_rec;
                        burst_len_o <= '0;
                    end
                end
                RECOVER:
                begin
                    // zero or one cycle of recovery both take a single cycle
                    if (rec_cnt <= `HC_REC_W'(1))
                        state_q <= IDLE;
                    else
                        rec_cnt <= rec_cnt - `HC_REC_W'(1);
                end
                default:
                begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    a_no_launch_idle : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (state_q == IDLE) |-> !phy_trans_valid_o);

    // only SETUP may load a new count into an empty counter
    a_no_wrap : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (remained_o == '0 && state_q != SETUP) |=> (remained_o == '0));

endmodule

// File: src/write_mask_gen.sv
// registered head and tail byte masks for hyperbus writes

`timescale 1ns/1ns

module write_mask_gen
    import hyper_ctrl_pkg::*;
(
    input  logic            clk_i,
    input  logic            rst_ni,

    txn_if.mask_mp          txn,

    input  ctrl_state_e     state_i,
    input  size_t           remained_i,   // words left before this beat
    input  logic            tx_valid_i,
    input  logic            tx_ready_i,

    output byte_mask_t      mask_o
);

    byte_mask_t head_mask;
    byte_mask_t tail_mask;
    logic       wr_beat;

    assign wr_beat = tx_valid_i & tx_ready_i & ~txn.rw;

    ////////////////////////////////////////
    // mask selection
    ////////////////////////////////////////

    // odd start drops the lower byte, a single byte drops the upper one
    assign head_mask = txn.odd_start               ? 2'b01
                     : (txn.size == size_t'(1))    ? 2'b10
                     : 2'b00;

    // next beat is the last one and it carries only the lower byte
    assign tail_mask = ((remained_i <= size_t'(2)) && txn.tail_odd) ? 2'b10 : 2'b00;

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            mask_o <= 2'b00;
        end
        else
        begin
            case (state_i)
                IDLE:    mask_o <= 2'b00;
                SETUP:   mask_o <= head_mask;   // ready for the first beat
                XFER:
                begin
                    if (wr_beat)
                        mask_o <= tail_mask;
                end
                default: mask_o <= mask_o;      // held through REG_W and RECOVER
            endcase
        end
    end

endmodule

// File: src/hyper_ctrl_top.sv
// hyperbus sequencer top level wiring the capture, the FSM and the mask generator

`timescale 1ns/1ns

`include "hyper_ctrl_consts.svh"

module hyper_ctrl_top
    import hyper_ctrl_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_ni,

    // transfer descriptor
    input  logic                    txn_valid_i,
    output logic                    txn_ready_o,
    input  logic                    txn_rw_i,
    input  logic                    txn_reg_space_i,
    input  addr_t                   txn_addr_i,
    input  size_t                   txn_size_i,
    input  cs_sel_t                 txn_cs_i,
    input  logic [`HC_REC_W-1:0]    t_rw_recovery_i,

    // PHY side
    output logic                    phy_trans_valid_o,
    input  logic                    phy_trans_ready_i,
    input  logic                    tx_valid_i,
    input  logic                    tx_ready_i,
    input  logic                    rx_valid_i,
    input  logic                    rx_ready_i,

    output size_t                   burst_len_o,
    output size_t                   remained_o,
    output logic [`HC_NR_CS-1:0]    cs_o,
    output logic                    odd_start_o,
    output byte_mask_t              mask_o
);

    logic           accept;
    ctrl_state_e    state;

    txn_if txn ();

    txn_capture u_capture (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .accept_i        (accept),
        .txn_rw_i        (txn_rw_i),
        .txn_reg_space_i (txn_reg_space_i),
        .txn_addr_i      (txn_addr_i),
        .txn_size_i      (txn_size_i),
        .txn_cs_i        (txn_cs_i),
        .t_rw_recovery_i (t_rw_recovery_i),
        .txn             (txn.capture_mp)
    );

    trans_sequencer u_seq (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .txn_valid_i       (txn_valid_i),
        .txn_ready_o       (txn_ready_o),
        .accept_o          (accept),
        .txn               (txn.seq_mp),
        .phy_trans_valid_o (phy_trans_valid_o),
        .phy_trans_ready_i (phy_trans_ready_i),
        .tx_valid_i        (tx_valid_i),
        .tx_ready_i        (tx_ready_i),
        .rx_valid_i        (rx_valid_i),
        .rx_ready_i        (rx_ready_i),
        .burst_len_o       (burst_len_o),
        .remained_o        (remained_o),
        .state_o           (state)
    );

    write_mask_gen u_mask (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .txn        (txn.mask_mp),
        .state_i    (state),
        .remained_i (remained_o),
        .tx_valid_i (tx_valid_i),
        .tx_ready_i (tx_ready_i),
        .mask_o     (mask_o)
    );

    assign cs_o        = txn.cs_onehot;
    assign odd_start_o = txn.odd_start;

endmodule

// File: sim/tb_hyper_ctrl.sv
// testbench with clock, reset, random descriptors, reference model, checker and watchdog

`timescale 1ns/1ns

`include "hyper_ctrl_consts.svh"

module tb_hyper_ctrl import hyper_ctrl_pkg::*; ();

    localparam int CLK_PERIOD  = 4;
    localparam int N_DATA      = 24;
    localparam int N_REG       = 4;
    localparam int MAX_SIZE    = 12;   // bytes per random burst
    localparam int MAX_REC     = 8;
    localparam int MAX_WORDS   = MAX_SIZE / 2 + 1;
    // worst case of one transaction including random beat gaps
    localparam int TXN_CYCLES  = 16 + 16 * MAX_WORDS + `HC_REG_W_WAIT + 1 + MAX_REC;
    localparam int WATCHDOG_NS = (20 + (N_DATA + N_REG + 1) * TXN_CYCLES) * CLK_PERIOD;

    typedef struct packed {
        size_t                  words;
        logic [`HC_NR_CS-1:0]   cs;
        logic                   odd_start;
        byte_mask_t             head;
        byte_mask_t             tail;
    } exp_txn_t;

    logic                   clk_i;
    logic                   rst_ni;
    logic                   txn_valid_i;
    logic                   txn_ready_o;
    logic                   txn_rw_i;
    logic                   txn_reg_space_i;
    addr_t                  txn_addr_i;
    size_t                  txn_size_i;
    cs_sel_t                txn_cs_i;
    logic [`HC_REC_W-1:0]   t_rw_recovery_i;
    logic                   phy_trans_valid_o;
    logic                   phy_trans_ready_i;
    logic                   tx_valid_i;
    logic                   tx_ready_i;
    logic                   rx_valid_i;
    logic                   rx_ready_i;
    size_t                  burst_len_o;
    size_t                  remained_o;
    logic [`HC_NR_CS-1:0]   cs_o;
    logic                   odd_start_o;
    byte_mask_t             mask_o;

    exp_txn_t   cur;                    // expectation of the running transaction
    logic       cur_rw      = 1'b0;
    logic       run_checks  = 1'b0;
    logic       xfer_phase  = 1'b0;     // set on the launch edge
    logic       xfer_seen   = 1'b0;
    size_t      exp_rem     = '0;
    int         err_cnt     = 0;
    int         chk_cnt     = 0;
    int         test_cnt    = 0;

    hyper_ctrl_top dut0 (.*);

    initial
    begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    ////////////////////////////////////////
    // reference model and helpers
    ////////////////////////////////////////

    function automatic exp_txn_t expected_txn(input logic rw, input logic reg_space,
                                              input addr_t addr, input size_t size,
                                              input cs_sel_t cs);
        exp_txn_t e;
        e.words = size_t'(size >> 1) + size_t'(size[0] | addr[0]);
        if (reg_space && !rw)
            e.words = '0;   // register writes carry no beats
        e.cs        = '0;
        e.cs[cs]    = 1'b1;
        e.odd_start = addr[0];
        e.head      = addr[0] ? 2'b01 : ((size == size_t'(1)) ? 2'b10 : 2'b00);
        e.tail      = (addr[0] ^ size[0]) ? 2'b10 : 2'b00;
        return e;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        chk_cnt++;
        assert (got === exp)
        else
        begin
            err_cnt++;
            $display("CHECK FAILED at %0t ns: %s expected %0h got %0h", $time, name, exp, got);
        end
    endtask

    task automatic report_test(input string what, input int err_start);
        test_cnt++;
        if (err_cnt == err_start)
            $display("test %0d %s: ok", test_cnt, what);
        else
            $display("test %0d %s: %0d errors", test_cnt, what, err_cnt - err_start);
    endtask

    // counts clock edges until txn_ready_o is seen high
    task automatic wait_ready_rise(output int cycles);
        logic done;
        cycles = 0;
        done   = 1'b0;
        while (!done)
        begin
            @(negedge clk_i);
            done = txn_ready_o || (cycles >= TXN_CYCLES);
            if (!done)
                cycles++;
        end
        if (!txn_ready_o)
        begin
            err_cnt++;
            $display("txn_ready_o did not come back within %0d cycles at %0t ns",
                     TXN_CYCLES, $time);
        end
    endtask

    // returns on the acceptance edge
    task automatic send_desc(input logic rw, input logic reg_space, input addr_t addr,
                             input size_t size, input cs_sel_t cs,
                             input logic [`HC_REC_W-1:0] t_rec);
        cur    = expected_txn(rw, reg_space, addr, size, cs);
        cur_rw = rw;
        @(posedge clk_i);
        txn_valid_i     <= 1'b1;
        txn_rw_i        <= rw;
        txn_reg_space_i <= reg_space;
        txn_addr_i      <= addr;
        txn_size_i      <= size;
        txn_cs_i        <= cs;
        t_rw_recovery_i <= t_rec;
        @(negedge clk_i);
        check_eq("txn_ready_o", 32'(txn_ready_o), 32'd1);
        @(posedge clk_i);
        txn_valid_i <= 1'b0;
    endtask

    task automatic launch_phy(input int unsigned gap);
        int waited;
        waited = 0;
        @(negedge clk_i);
        while (!phy_trans_valid_o && waited < 8)
        begin
            @(negedge clk_i);
            waited++;
        end
        if (!phy_trans_valid_o)
        begin
            err_cnt++;
            $display("phy_trans_valid_o never rose after acceptance at %0t ns", $time);
        end
        repeat (gap)
        begin
            @(posedge clk_i);
            @(negedge clk_i);
            check_eq("phy_trans_valid_o", 32'(phy_trans_valid_o), 32'd1);   // held under back-pressure
        end
        @(posedge clk_i);
        phy_trans_ready_i <= 1'b1;
        @(posedge clk_i);
        phy_trans_ready_i <= 1'b0;
        xfer_phase = 1'b1;
    endtask

    // other direction toggles at random and must not count
    task automatic run_beats(input logic rw, input size_t words);
        size_t  sent;
        logic   v;
        logic   r;
        sent = '0;
        while (sent < words)
        begin
            v = ($urandom % 4) != 0;
            r = ($urandom % 4) != 0;
            if (rw)
            begin
                rx_valid_i <= v;
                rx_ready_i <= r;
                tx_valid_i <= 1'($urandom % 2);
                tx_ready_i <= 1'($urandom % 2);
            end
            else
            begin
                tx_valid_i <= v;
                tx_ready_i <= r;
                rx_valid_i <= 1'($urandom % 2);
                rx_ready_i <= 1'($urandom % 2);
            end
            if (v && r)
                sent = sent + size_t'(1);
            @(posedge clk_i);
        end
        tx_valid_i <= 1'b0;
        tx_ready_i <= 1'b0;
        rx_valid_i <= 1'b0;
        rx_ready_i <= 1'b0;
    endtask

    task automatic data_test();
        logic                   rw;
        addr_t                  addr;
        size_t                  size;
        cs_sel_t                cs;
        logic [`HC_REC_W-1:0]   t_rec;
        int unsigned            gap;
        int                     cycles;
        int                     err_start;
        rw        = 1'($urandom % 2);
        addr      = $urandom;
        size      = size_t'(1 + $urandom % MAX_SIZE);
        cs        = cs_sel_t'($urandom % `HC_NR_CS);
        t_rec     = `HC_REC_W'(1 + $urandom % MAX_REC);
        gap       = $urandom % 4;
        err_start = err_cnt;
        send_desc(rw, 1'b0, addr, size, cs, t_rec);
        launch_phy(gap);
        run_beats(rw, cur.words);
        wait_ready_rise(cycles);
        check_eq("recovery cycles", 32'(cycles), 32'(t_rec) + 32'd1);
        @(posedge clk_i);
        xfer_phase = 1'b0;
        report_test($sformatf("%s size %0d addr %h cs %0d rec %0d", rw ? "read" : "write",
                              size, addr, cs, t_rec), err_start);
    endtask

    task automatic reg_write_test();
        addr_t                  addr;
        cs_sel_t                cs;
        logic [`HC_REC_W-1:0]   t_rec;
        int                     cycles;
        int                     err_start;
        addr      = $urandom;
        cs        = cs_sel_t'($urandom % `HC_NR_CS);
        t_rec     = `HC_REC_W'(1 + $urandom % MAX_REC);
        err_start = err_cnt;
        @(posedge clk_i);
        phy_trans_ready_i <= 1'b1;   // PHY takes the launch at once
        send_desc(1'b0, 1'b1, addr, size_t'(2), cs, t_rec);
        wait_ready_rise(cycles);
        // SETUP 2, REG_W wait+1, RECOVER t_rec, ready one cycle later
        check_eq("register write latency", 32'(cycles),
                 32'd2 + 32'(`HC_REG_W_WAIT + 1) + 32'(t_rec) + 32'd1);
        @(posedge clk_i);
        phy_trans_ready_i <= 1'b0;
        report_test($sformatf("register write rec %0d", t_rec), err_start);
    endtask

    ////////////////////////////////////////
    // checker on the falling edge
    ////////////////////////////////////////

    always @(negedge clk_i)
    begin
        if (rst_ni && run_checks)
        begin
            if (phy_trans_valid_o)
            begin
                check_eq("burst_len_o", 32'(burst_len_o), 32'(cur.words));
                check_eq("cs_o", 32'(cs_o), 32'(cur.cs));
                check_eq("odd_start_o", 32'(odd_start_o), 32'(cur.odd_start));
            end
            if (xfer_phase && !xfer_seen)
            begin
                exp_rem   = cur.words;
                xfer_seen = 1'b1;
                check_eq("phy_trans_valid_o", 32'(phy_trans_valid_o), 32'd0);
            end
            else if (!xfer_phase)
            begin
                xfer_seen = 1'b0;
            end
            if (xfer_phase)
            begin
                check_eq("remained_o", 32'(remained_o), 32'(exp_rem));
                if (!cur_rw && tx_valid_i && tx_ready_i)
                begin
                    if (exp_rem == cur.words)
                        check_eq("mask_o head", 32'(mask_o), 32'(cur.head));
                    else if (exp_rem == size_t'(1))
                        check_eq("mask_o tail", 32'(mask_o), 32'(cur.tail));
                    else
                        check_eq("mask_o middle", 32'(mask_o), 32'd0);
                end
                if ((cur_rw ? (rx_valid_i && rx_ready_i) : (tx_valid_i && tx_ready_i))
                    && exp_rem != '0)
                    exp_rem = exp_rem - size_t'(1);
            end
        end
    end

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial
    begin
        int err_start;
        void'($urandom(76));
        rst_ni            <= 1'b0;
        txn_valid_i       <= 1'b0;
        txn_rw_i          <= 1'b0;
        txn_reg_space_i   <= 1'b0;
        txn_addr_i        <= '0;
        txn_size_i        <= '0;
        txn_cs_i          <= '0;
        t_rw_recovery_i   <= '0;
        phy_trans_ready_i <= 1'b0;
        tx_valid_i        <= 1'b0;
        tx_ready_i        <= 1'b0;
        rx_valid_i        <= 1'b0;
        rx_ready_i        <= 1'b0;
        repeat (10) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(posedge clk_i);
        @(negedge clk_i);
        err_start = err_cnt;
        check_eq("txn_ready_o", 32'(txn_ready_o), 32'd1);
        check_eq("phy_trans_valid_o", 32'(phy_trans_valid_o), 32'd0);
        check_eq("burst_len_o", 32'(burst_len_o), 32'd0);
        check_eq("remained_o", 32'(remained_o), 32'd0);
        check_eq("mask_o", 32'(mask_o), 32'd0);
        report_test("reset values", err_start);
        @(posedge clk_i);
        run_checks = 1'b1;

        for (int i = 0; i < N_DATA; i++)
            data_test();
        for (int i = 0; i < N_REG; i++)
            reg_write_test();

        $display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0)
        begin
            $display("Simulation passed");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

    // ends a run that hangs on a handshake
    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, a transaction never completed", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: hyper_ctrl_top.f
+incdir+src
src/hyper_ctrl_pkg.sv
src/txn_if.sv
src/txn_capture.sv
src/trans_sequencer.sv
src/write_mask_gen.sv
src/hyper_ctrl_top.sv
sim/tb_hyper_ctrl.sv

// File: Makefile
# Verilator flow for the HyperBus sequencer

VERILATOR ?= verilator
FILELIST  ?= hyper_ctrl_top.f
RTL_TOP   ?= hyper_ctrl_top
TB_TOP    ?= tb_hyper_ctrl
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?=
PASS_MSG  ?= Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
